/* filelist.f */
+incdir+rtl
rtl/vga_pkg.sv
rtl/wb_pkg.sv
rtl/vga_timing.sv
rtl/vga_regs.sv
rtl/vga_fetch.sv
rtl/vga_pixel.sv
rtl/vga_top.sv
bench/vga_tb.sv

/* bench/vga_tests.dat */
# kind name then four hex fields: W adr dat, R adr expected, P mode x y rgb,
# A mode request_index adr, L wait_cycles row visible; unused fields are 0
R rst_base0 0 00 0 0
R rst_base1 1 00 0 0
R rst_base2 2 02 0 0
R rst_font0 4 00 0 0
R rst_font1 5 00 0 0
R rst_font2 6 04 0 0
R rst_mode f 00 0 0
W base0 0 00 0 0
W base1 1 01 0 0
W base2 2 00 0 0
R base2_staged 2 02 0 0
W base_set 3 00 0 0
R base0 0 00 0 0
R base1 1 01 0 0
R base2 2 00 0 0
W font1 5 08 0 0
W font2 6 fb 0 0
R font2_staged 6 04 0 0
W font_set 7 00 0 0
R font1 5 08 0 0
R font2 6 03 0 0
W pal0_b 8 30 0 0
W pal0_g 9 20 0 0
W pal0_r a 10 0 0
R pal_r_back a 10 0 0
W pal0_idx b 00 0 0
W pal1_b 8 c0 0 0
W pal1_g 9 b0 0 0
W pal1_r a a0 0 0
W pal1_idx b 01 0 0
P off_visible 0 64 c8 102030
P off_blank 0 a 1e1 000000
P g320_first 3 0 0 a0b0c0
P g320_byte1 3 3 0 102030
P g320_doubled 3 1 1 a0b0c0
P g320_row3 3 185 3 a0b0c0
A g320_row2_req 3 140 00240 0
P g640_hi 2 0 0 102030
P g640_lo 2 1 0 a0b0c0
P g640_row1 2 185 1 a0b0c0
A text_char 1 0 00100 0
A text_color 1 1 00101 0
A text_font 1 2 30808 0
L line_vis 1a130 64 1 0
L line_blank 1a90 1f4 0 0

/* bench/vga_tb.sv */
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_tb import vga_pkg::*; import wb_pkg::*; ();

    localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int MAX_TESTS = 128;

    logic       I_vga_clk = 1'b0;
    logic       I_reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    ram_req_t   ram_req;
    logic [7:0] ram_dat = 8'h00;
    logic       hsync;
    logic       vsync;
    rgb_t       rgb;

    ram_req_t    ram_seen = '0;
    ram_req_t    ram_stage [0:`VGA_RAM_LATENCY-2];
    string       kinds [0:MAX_TESTS-1];
    string       names [0:MAX_TESTS-1];
    logic [31:0] args0 [0:MAX_TESTS-1];
    logic [31:0] args1 [0:MAX_TESTS-1];
    logic [31:0] args2 [0:MAX_TESTS-1];
    logic [31:0] args3 [0:MAX_TESTS-1];
    int          num_tests = 0;
    int          error_count = 0;
    int          cycles = 0;
    int          limit = 0;
    integer      seed = 32'h0c30649b;

    vga_top dut_i (
        .I_vga_clk   (I_vga_clk),
        .I_reset     (I_reset),
        .I_wb        (wb_req),
        .O_wb        (wb_rsp),
        .O_ram       (ram_req),
        .I_ram_dat   (ram_dat),
        .O_vga_hsync (hsync),
        .O_vga_vsync (vsync),
        .O_vga_rgb   (rgb)
    );

    always #50 I_vga_clk = ~I_vga_clk;

    function automatic logic [7:0] ram_byte(input logic [18:0] adr);
        return adr[7:0] ^ adr[15:8];
    endfunction

    // ram model returning data the latency after the cycle holding the request
    always @(negedge I_vga_clk) begin
        ram_seen <= ram_req;
    end

    always @(posedge I_vga_clk) begin
        ram_stage[0] <= ram_seen;
        for (int i = 1; i <= `VGA_RAM_LATENCY - 2; i++) begin
            ram_stage[i] <= ram_stage[i - 1];
        end
        if (ram_stage[`VGA_RAM_LATENCY-2].req) begin
            ram_dat <= ram_byte(ram_stage[`VGA_RAM_LATENCY-2].adr);
        end else begin
            ram_dat <= 8'h00;
        end
    end

    always @(posedge I_vga_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch %s: expected %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch %s: expected %06h, actual %06h", name, exp, act));
        end
    endtask

    task automatic check_adr(input string name, input logic [18:0] exp,
                             input logic [18:0] act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch %s: expected %05h, actual %05h", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // the line register may lag or lead the estimate by one line
    task automatic check_line(input string name, input logic [9:0] exp,
                              input logic [9:0] act);
        if (act !== exp && act !== exp + 10'd1 && act !== exp - 10'd1) begin
            fail_now($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdat);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) @(posedge I_vga_clk);
        @(posedge I_vga_clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        @(negedge I_vga_clk);
        if (wb_rsp.ack) begin
            fail_now($sformatf("ack came in the same cycle as the access to %0h", adr));
        end
        @(negedge I_vga_clk);
        if (!wb_rsp.ack) begin
            fail_now($sformatf("no ack one cycle after the access to %0h", adr));
        end
        rdat = wb_rsp.dat;
        @(posedge I_vga_clk);
        wb_req <= '0;
    endtask

    // returns in the first cycle with vsync high while the beam is in row 492
    task automatic wait_frame_start();
        @(negedge I_vga_clk);
        while (vsync !== 1'b0) @(negedge I_vga_clk);
        while (vsync !== 1'b1) @(negedge I_vga_clk);
    endtask

    task automatic run_pixel(input string name, input logic [1:0] mode, input int x,
                             input int y, input rgb_t exp);
        logic [7:0] rdat;
        string      sync_name;
        sync_name = $sformatf("%s_hsync", name);
        bus_access(1'b1, `VGA_REG_MODE, {6'd0, mode}, rdat);
        wait_frame_start();
        // outputs now describe column 15 of row y just before the sync pulse
        repeat ((`VGA_V_BACK + y) * `VGA_H_TOTAL + `VGA_H_FRONT - 1) @(negedge I_vga_clk);
        check_level(sync_name, 1'b1, hsync);
        @(negedge I_vga_clk);
        check_level(sync_name, 1'b0, hsync);
        repeat (`VGA_H_PULSE - 1) @(negedge I_vga_clk);
        check_level(sync_name, 1'b0, hsync);
        @(negedge I_vga_clk);
        check_level(sync_name, 1'b1, hsync);
        // pixel x follows the rising hsync by the back porch plus x
        repeat (`VGA_H_BACK + x) @(negedge I_vga_clk);
        check_rgb(name, exp, rgb);
    endtask

    task automatic run_request(input string name, input logic [1:0] mode, input int idx,
                               input logic [18:0] exp);
        logic [7:0] rdat;
        int         seen;
        bus_access(1'b1, `VGA_REG_MODE, {6'd0, mode}, rdat);
        wait_frame_start();
        seen = -1;
        while (seen < idx) begin
            @(negedge I_vga_clk);
            if (ram_req.req) begin
                seen++;
            end
        end
        check_adr(name, exp, ram_req.adr);
    endtask

    task automatic run_line(input string name, input int wait_cycles, input logic [9:0] row,
                            input logic vis);
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] flag;
        wait_frame_start();
        repeat (wait_cycles) @(negedge I_vga_clk);
        bus_access(1'b0, `VGA_REG_LINE_LO, 8'h00, lo);
        bus_access(1'b0, `VGA_REG_LINE_HI, 8'h00, hi);
        bus_access(1'b0, `VGA_REG_VISIBLE, 8'h00, flag);
        check_line(name, row, {hi[1:0], lo});
        check_byte(name, {7'd0, vis}, flag);
    endtask

    initial begin
        int               fd;
        int               count;
        int               frame_tests;
        int               bus_tests;
        logic [8*160-1:0] line;
        string            kind;
        string            name;
        logic [31:0]      v0;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [31:0]      v3;
        logic [7:0]       rdat;

        I_reset = 1'b1;
        wb_req = '0;
        ram_stage[0] = '0;
        frame_tests = 0;
        bus_tests = 0;

        fd = $fopen("bench/vga_tests.dat", "r");
        if (fd == 0) begin
            fail_now("cannot open the test file bench/vga_tests.dat");
        end
        while ($fgets(line, fd) != 0) begin
            count = $sscanf(line, "%s %s %h %h %h %h", kind, name, v0, v1, v2, v3);
            if (count >= 1 && kind != "#") begin
                if (count != 6) begin
                    fail_now($sformatf("test line %0d has missing fields", num_tests + 1));
                end
                kinds[num_tests] = kind;
                names[num_tests] = name;
                args0[num_tests] = v0;
                args1[num_tests] = v1;
                args2[num_tests] = v2;
                args3[num_tests] = v3;
                num_tests++;
                if (kind == "P" || kind == "A" || kind == "L") begin
                    frame_tests++;
                end else begin
                    bus_tests++;
                end
            end
        end
        $fclose(fd);
        limit = frame_tests * 2 * FRAME_CYCLES + bus_tests * 1000;

        repeat (3) @(posedge I_vga_clk);
        I_reset <= 1'b0;

        for (int t = 0; t < num_tests; t++) begin
            if (kinds[t] == "W") begin
                bus_access(1'b1, args0[t][3:0], args1[t][7:0], rdat);
            end else if (kinds[t] == "R") begin
                bus_access(1'b0, args0[t][3:0], 8'h00, rdat);
                check_byte(names[t], args1[t][7:0], rdat);
            end else if (kinds[t] == "P") begin
                run_pixel(names[t], args0[t][1:0], args1[t], args2[t], rgb_t'(args3[t][23:0]));
            end else if (kinds[t] == "A") begin
                run_request(names[t], args0[t][1:0], args1[t], args2[t][18:0]);
            end else if (kinds[t] == "L") begin
                run_line(names[t], args0[t], args1[t][9:0], args2[t][0]);
            end else begin
                fail_now($sformatf("unknown test kind %s in test %s", kinds[t], names[t]));
            end
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* rtl/vga_top.sv */
`timescale 1ns/1ps

module vga_top import vga_pkg::*; import wb_pkg::*; (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  wb_req_t    I_wb,
    output wb_rsp_t    O_wb,
    output ram_req_t   O_ram,
    input  logic [7:0] I_ram_dat,
    output logic       O_vga_hsync,
    output logic       O_vga_vsync,
    output rgb_t       O_vga_rgb
);

    beam_t       beam;
    vga_mode_e   mode;
    logic [18:0] ram_base;
    logic [18:0] font_base;
    pal_write_u  pal_wr;
    logic        pal_we;
    logic [7:0]  pix_byte;
    logic        font_bit;
    logic [7:0]  color_byte;

    vga_timing timing_i (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .beam      (beam),
        .hsync     (O_vga_hsync),
        .vsync     (O_vga_vsync)
    );

    vga_regs regs_i (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .wb_in     (I_wb),
        .wb_out    (O_wb),
        .beam      (beam),
        .mode      (mode),
        .ram_base  (ram_base),
        .font_base (font_base),
        .pal_wr    (pal_wr),
        .pal_we    (pal_we)
    );

    vga_fetch fetch_i (
        .I_vga_clk  (I_vga_clk),
        .I_reset    (I_reset),
        .beam       (beam),
        .mode       (mode),
        .ram_base   (ram_base),
        .font_base  (font_base),
        .ram        (O_ram),
        .I_ram_dat  (I_ram_dat),
        .pix_byte   (pix_byte),
        .font_bit   (font_bit),
        .color_byte (color_byte)
    );

    vga_pixel pixel_i (
        .I_vga_clk  (I_vga_clk),
        .beam       (beam),
        .mode       (mode),
        .pix_byte   (pix_byte),
        .font_bit   (font_bit),
        .color_byte (color_byte),
        .pal_wr     (pal_wr),
        .pal_we     (pal_we),
        .rgb        (O_vga_rgb)
    );

endmodule

/* rtl/vga_pixel.sv */
`timescale 1ns/1ps

module vga_pixel import vga_pkg::*; (
    input  logic       I_vga_clk,
    input  beam_t      beam,
    input  vga_mode_e  mode,
    input  logic [7:0] pix_byte,
    input  logic       font_bit,
    input  logic [7:0] color_byte,
    input  pal_write_u pal_wr,
    input  logic       pal_we,
    output rgb_t       rgb
);

    rgb_t       palette [0:255];
    logic [7:0] pal_idx;

    always_comb begin
        case (mode)
            mode_gfx_320: pal_idx = pix_byte;
            // even column takes the high nibble
            mode_gfx_640: pal_idx = {4'h0, beam.col[0] ? pix_byte[3:0] : pix_byte[7:4]};
            mode_text_40: pal_idx = {4'h0, font_bit ? color_byte[7:4] : color_byte[3:0]};
            default:      pal_idx = 8'd0;
        endcase
    end

    always_ff @(posedge I_vga_clk) begin
        if (pal_we) begin
            palette[pal_wr.entry.idx] <= '{
                r: pal_wr.entry.r,
                g: pal_wr.entry.g,
                b: pal_wr.entry.b
            };
        end
    end

    // blanking forces black
    always_ff @(posedge I_vga_clk) begin
        if (beam.col_vis && beam.row_vis) begin
            rgb <= palette[pal_idx];
        end else begin
            rgb <= '0;
        end
    end

endmodule

/* rtl/vga_fetch.sv */
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_fetch import vga_pkg::*; (
    input  logic        I_vga_clk,
    input  logic        I_reset,
    input  beam_t       beam,
    input  vga_mode_e   mode,
    input  logic [18:0] ram_base,
    input  logic [18:0] font_base,
    output ram_req_t    ram,
    input  logic [7:0]  I_ram_dat,
    output logic [7:0]  pix_byte,
    output logic        font_bit,
    output logic [7:0]  color_byte
);

    localparam int LAT = `VGA_RAM_LATENCY;
    localparam logic [9:0] H_START = `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK;
    localparam logic [9:0] H_LAST = `VGA_H_TOTAL - 1;
    localparam logic [9:0] V_LAST = `VGA_V_TOTAL - 1;
    localparam logic [9:0] SPAN = `VGA_H_VISIBLE;
    // request register, latency and capture register ahead of the beam
    localparam logic [9:0] GFX_FIRST = H_START - 10'(LAT + 2);
    // text cells are fetched one 16-pixel cell ahead
    localparam logic [9:0] TXT_FIRST = H_START - 10'd16;
    localparam logic [3:0] PH_CHAR = 4'd0;
    localparam logic [3:0] PH_COLOR = 4'd1;
    localparam logic [3:0] PH_FONT = 4'(LAT + 2);
    localparam logic [3:0] PH_SWAP = 4'd15;

    // what the data word in flight is for
    localparam logic [2:0] K_NONE = 3'd0;
    localparam logic [2:0] K_GFX = 3'd1;
    localparam logic [2:0] K_REPLAY = 3'd2;
    localparam logic [2:0] K_CHAR = 3'd3;
    localparam logic [2:0] K_COLOR = 3'd4;
    localparam logic [2:0] K_FONT = 3'd5;

    logic [7:0]  line_cache [0:319];
    logic [2:0]  kind_pipe [0:LAT];
    logic [2:0]  issue_kind;
    logic [18:0] issue_adr;
    logic [18:0] line_adr;
    logic [9:0]  gfx_off;
    logic        in_gfx;
    logic        in_text;
    logic [8:0]  gfx_idx;
    logic [8:0]  cache_idx;
    logic [5:0]  text_col;
    logic [7:0]  char_byte;
    logic [7:0]  color_next;
    logic [7:0]  font_next;
    logic [7:0]  font_cur;

    assign gfx_off = beam.col - GFX_FIRST;
    assign in_gfx = (mode == mode_gfx_640 || mode == mode_gfx_320) && beam.row_vis &&
                    beam.col >= GFX_FIRST && gfx_off < SPAN && !gfx_off[0];
    assign in_text = mode == mode_text_40 && beam.row_vis &&
                     beam.col >= TXT_FIRST && beam.col < TXT_FIRST + SPAN;
    // msb of the font byte is the leftmost pixel pair
    assign font_bit = font_cur[3'd7 - beam.col[3:1]];

    always_comb begin
        issue_kind = K_NONE;
        issue_adr  = line_adr;
        if (in_gfx) begin
            // odd lines of the doubled mode come back from the cache
            issue_kind = (mode == mode_gfx_320 && beam.row[0]) ? K_REPLAY : K_GFX;
            issue_adr  = line_adr + 19'(gfx_idx);
        end else if (in_text) begin
            case (beam.col[3:0])
                PH_CHAR: begin
                    issue_kind = K_CHAR;
                    issue_adr  = line_adr + 19'({text_col, 1'b0});
                end
                PH_COLOR: begin
                    issue_kind = K_COLOR;
                    issue_adr  = line_adr + 19'({text_col, 1'b1});
                end
                PH_FONT: begin
                    issue_kind = K_FONT;
                    issue_adr  = font_base + 19'({char_byte, beam.row[3:1]});
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            ram       <= '0;
            line_adr  <= `VGA_RESET_RAM_BASE;
            gfx_idx   <= '0;
            cache_idx <= '0;
            text_col  <= '0;
            for (int i = 0; i <= LAT; i++) begin
                kind_pipe[i] <= K_NONE;
            end
        end else begin
            ram.req      <= issue_kind inside {K_GFX, K_CHAR, K_COLOR, K_FONT};
            ram.adr      <= issue_adr;
            kind_pipe[0] <= issue_kind;
            for (int i = 1; i <= LAT; i++) begin
                kind_pipe[i] <= kind_pipe[i - 1];
            end
            if (in_gfx) begin
                gfx_idx <= gfx_idx + 9'd1;
            end
            if (kind_pipe[LAT] == K_GFX || kind_pipe[LAT] == K_REPLAY) begin
                cache_idx <= cache_idx + 9'd1;
            end
            if (in_text && beam.col[3:0] == PH_SWAP) begin
                text_col <= text_col + 6'd1;
            end
            if (beam.col == H_LAST) begin
                gfx_idx   <= '0;
                cache_idx <= '0;
                text_col  <= '0;
                if (beam.row == V_LAST) begin
                    line_adr <= ram_base;
                end else if (beam.row_vis) begin
                    case (mode)
                        mode_gfx_640: line_adr <= line_adr + 19'd320;
                        mode_gfx_320: if (beam.row[0]) line_adr <= line_adr + 19'd320;
                        mode_text_40: if (beam.row[3:0] == 4'hf) line_adr <= line_adr + 19'd80;
                        default: ;
                    endcase
                end
            end
        end
    end

    // returning data, line cache and the text cell handover
    always_ff @(posedge I_vga_clk) begin
        case (kind_pipe[LAT])
            K_GFX: begin
                pix_byte              <= I_ram_dat;
                line_cache[cache_idx] <= I_ram_dat;
            end
            K_REPLAY: pix_byte <= line_cache[cache_idx];
            K_CHAR:   char_byte <= I_ram_dat;
            K_COLOR:  color_next <= I_ram_dat;
            K_FONT:   font_next <= I_ram_dat;
            default: ;
        endcase
        if (in_text && beam.col[3:0] == PH_SWAP) begin
            font_cur   <= font_next;
            color_byte <= color_next;
        end
    end

endmodule

/* rtl/vga_regs.sv */
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_regs import vga_pkg::*; import wb_pkg::*; (
    input  logic        I_vga_clk,
    input  logic        I_reset,
    input  wb_req_t     wb_in,
    output wb_rsp_t     wb_out,
    input  beam_t       beam,
    output vga_mode_e   mode,
    output logic [18:0] ram_base,
    output logic [18:0] font_base,
    output pal_write_u  pal_wr,
    output logic        pal_we
);

    logic        active;
    logic        ack_q;
    logic [7:0]  dat_q;
    logic [18:0] stage;
    logic [1:0]  row_hi;

    // one access per cycle, the ack cycle itself is not taken as a new request
    assign active = wb_in.cyc && wb_in.stb && !ack_q;
    assign wb_out = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            ack_q     <= 1'b0;
            pal_we    <= 1'b0;
            mode      <= mode_off;
            ram_base  <= `VGA_RESET_RAM_BASE;
            font_base <= `VGA_RESET_FONT_BASE;
        end else begin
            ack_q  <= active;
            pal_we <= active && wb_in.we && wb_in.adr == `VGA_REG_PAL_IDX;
            if (active && wb_in.we) begin
                case (wb_in.adr)
                    `VGA_REG_BASE_SET: ram_base <= stage;
                    `VGA_REG_FONT_SET: font_base <= stage;
                    `VGA_REG_MODE:     mode <= vga_mode_e'(wb_in.dat[1:0]);
                    default: ;
                endcase
            end
        end
    end

    // staging bytes and read data
    always_ff @(posedge I_vga_clk) begin
        if (active && wb_in.we) begin
            case (wb_in.adr)
                `VGA_REG_BASE0, `VGA_REG_FONT0: stage[7:0] <= wb_in.dat;
                `VGA_REG_BASE1, `VGA_REG_FONT1: stage[15:8] <= wb_in.dat;
                `VGA_REG_BASE2, `VGA_REG_FONT2: stage[18:16] <= wb_in.dat[2:0];
                `VGA_REG_PAL_B:   pal_wr.word[7:0] <= wb_in.dat;
                `VGA_REG_PAL_G:   pal_wr.word[15:8] <= wb_in.dat;
                `VGA_REG_PAL_R:   pal_wr.word[23:16] <= wb_in.dat;
                `VGA_REG_PAL_IDX: pal_wr.word[31:24] <= wb_in.dat;
                default: ;
            endcase
        end
        if (active && !wb_in.we) begin
            case (wb_in.adr)
                `VGA_REG_BASE0:   dat_q <= ram_base[7:0];
                `VGA_REG_BASE1:   dat_q <= ram_base[15:8];
                `VGA_REG_BASE2:   dat_q <= {5'd0, ram_base[18:16]};
                `VGA_REG_FONT0:   dat_q <= font_base[7:0];
                `VGA_REG_FONT1:   dat_q <= font_base[15:8];
                `VGA_REG_FONT2:   dat_q <= {5'd0, font_base[18:16]};
                `VGA_REG_PAL_B:   dat_q <= pal_wr.word[7:0];
                `VGA_REG_PAL_G:   dat_q <= pal_wr.word[15:8];
                `VGA_REG_PAL_R:   dat_q <= pal_wr.word[23:16];
                `VGA_REG_PAL_IDX: dat_q <= pal_wr.word[31:24];
                `VGA_REG_LINE_LO: begin
                    dat_q  <= beam.row[7:0];
                    // high bits frozen so a 0xD read matches this low byte
                    row_hi <= beam.row[9:8];
                end
                `VGA_REG_LINE_HI: dat_q <= {6'd0, row_hi};
                `VGA_REG_VISIBLE: dat_q <= {7'd0, beam.row_vis};
                `VGA_REG_MODE:    dat_q <= {6'd0, mode};
                default:          dat_q <= 8'd0;
            endcase
        end
    end

endmodule

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_timing import vga_pkg::*; (
    input  logic  I_vga_clk,
    input  logic  I_reset,
    output beam_t beam,
    output logic  hsync,
    output logic  vsync
);

    localparam logic [9:0] H_START = `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK;
    localparam logic [9:0] H_LAST = `VGA_H_TOTAL - 1;
    localparam logic [9:0] HS_FIRST = `VGA_H_FRONT;
    localparam logic [9:0] HS_END = `VGA_H_FRONT + `VGA_H_PULSE;
    localparam logic [9:0] V_LAST = `VGA_V_TOTAL - 1;
    localparam logic [9:0] V_VIS_LAST = `VGA_V_VISIBLE - 1;
    localparam logic [9:0] VS_FIRST = `VGA_V_VISIBLE + `VGA_V_FRONT;
    localparam logic [9:0] VS_END = `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_PULSE;

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            beam.col     <= '0;
            beam.row     <= '0;
            beam.col_vis <= 1'b0;
            beam.row_vis <= 1'b1;
            hsync        <= 1'b1;
            vsync        <= 1'b1;
        end else begin
            // sync levels lag the beam by one cycle, like the rgb register
            hsync <= !(beam.col >= HS_FIRST && beam.col < HS_END);
            vsync <= !(beam.row >= VS_FIRST && beam.row < VS_END);

            if (beam.col == H_START - 10'd1) begin
                beam.col_vis <= 1'b1;
            end

            if (beam.col == H_LAST) begin
                beam.col     <= '0;
                beam.col_vis <= 1'b0;
                if (beam.row == V_LAST) begin
                    beam.row     <= '0;
                    beam.row_vis <= 1'b1;
                end else begin
                    beam.row <= beam.row + 10'd1;
                end
                if (beam.row == V_VIS_LAST) begin
                    beam.row_vis <= 1'b0;
                end
            end else begin
                beam.col <= beam.col + 10'd1;
            end
        end
    end

endmodule

/* rtl/wb_pkg.sv */
package wb_pkg;

    // classic cycle from the master, 8-bit data and 4-bit register address
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

endpackage

/* rtl/vga_pkg.sv */
package vga_pkg;

    typedef enum logic [1:0] {
        mode_off     = 2'b00,
        mode_text_40 = 2'b01,
        mode_gfx_640 = 2'b10,
        mode_gfx_320 = 2'b11
    } vga_mode_e;

    // beam position, flags registered together with the counters
    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       col_vis;
        logic       row_vis;
    } beam_t;

    typedef struct packed {
        logic        req;
        logic [18:0] adr;
    } ram_req_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [7:0] idx;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pal_entry_t;

    // filled byte-wise by the bus, consumed as an entry by the palette
    typedef union packed {
        logic [31:0] word;
        pal_entry_t  entry;
    } pal_write_u;

endpackage

/* rtl/vga_consts.svh */
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// horizontal timing in pixel clocks
`define VGA_H_VISIBLE 640
`define VGA_H_FRONT 16
`define VGA_H_PULSE 96
`define VGA_H_BACK 48
`define VGA_H_TOTAL (`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK)

// vertical timing in lines
`define VGA_V_VISIBLE 480
`define VGA_V_FRONT 10
`define VGA_V_PULSE 2
`define VGA_V_BACK 33
`define VGA_V_TOTAL (`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_PULSE + `VGA_V_BACK)

// register port offsets
`define VGA_REG_BASE0 4'h0
`define VGA_REG_BASE1 4'h1
`define VGA_REG_BASE2 4'h2
`define VGA_REG_BASE_SET 4'h3
`define VGA_REG_FONT0 4'h4
`define VGA_REG_FONT1 4'h5
`define VGA_REG_FONT2 4'h6
`define VGA_REG_FONT_SET 4'h7
`define VGA_REG_PAL_B 4'h8
`define VGA_REG_PAL_G 4'h9
`define VGA_REG_PAL_R 4'hA
`define VGA_REG_PAL_IDX 4'hB
`define VGA_REG_LINE_LO 4'hC
`define VGA_REG_LINE_HI 4'hD
`define VGA_REG_VISIBLE 4'hE
`define VGA_REG_MODE 4'hF

// base addresses after reset
`define VGA_RESET_RAM_BASE 19'h20000
`define VGA_RESET_FONT_BASE 19'h40000

// cycles from a request to its data
`define VGA_RAM_LATENCY 2

`endif
